// ==== tb/fetch_stimulus.txt ====
// @00 memory: err, addr, data | @10 squash map: 0, jalr or fault pc, squash pc
// @18 expected: pc, inst, {br_kind, except}; br_kind 0 none 1 cond 2 jal 3 jalr
@00
0_00000100_00100093
0_00000104_00200113
0_00000108_00208463
0_0000010C_00300193
0_00000110_0200006F
0_00000130_00400213
0_00000134_00008067
0_00000200_00600313
0_00000204_0040006F
0_00000208_00209463
1_0000020C_DEADBEEF
0_00000300_00700393
0_00000304_00C0006F
0_00000310_00800413
0_00000314_00900493
@10
0_00000134_00000200
0_0000020C_00000302
@18
00000100_00100093_0
00000104_00200113_0
00000108_00208463_4
0000010C_00300193_0
00000110_0200006F_8
00000130_00400213_0
00000134_00008067_C
00000200_00600313_0
00000204_0040006F_8
00000208_00209463_4
0000020C_DEADBEEF_1
00000300_00700393_0
00000304_00C0006F_8
00000310_00800413_0
00000314_00900493_0

// ==== fetch_unit.f ====
+incdir+verilog
verilog/fetch_pkg.sv
verilog/fetch_req_gen.sv
verilog/fetch_resp_buffer.sv
verilog/pre_decoder.sv
verilog/fetch_top.sv
tb/tb_fetch_top.sv

// ==== run_sim.sh ====
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary -j 0 -Wno-fatal --top-module tb_fetch_top -f fetch_unit.f \
    && ./obj_dir/Vtb_fetch_top > sim.log 2>&1 \
    || { echo "build or simulation failed"; exit 1; }
cat sim.log
grep -q "Done: errors found" sim.log \
    && { echo "FAIL"; exit 1; } \
    || { echo "PASS"; exit 0; }

// ==== tb/tb_fetch_top.sv ====
`timescale 1ns/1ps
`include "fetch_params.svh"

module tb_fetch_top import fetch_pkg::*; ();

    // section offsets in the stimulus image of tb/fetch_stimulus.txt
    localparam int STIM_SIZE = 48;
    localparam int MEM_BASE  = 'h00;
    localparam int SQ_BASE   = 'h10;
    localparam int EXP_BASE  = 'h18;

    logic         clk;
    logic         rst_n;
    logic         arvalid;
    xaddr_t       araddr;
    logic         arready;
    logic         rvalid;
    inst_t        rdata;
    logic [1:0]   rresp;
    logic         rready;
    logic         stall;
    logic         squash;
    xaddr_t       squash_pc;
    logic         fetch_vld;
    fetch_entry_t fetch_entry;

    logic [67:0]  stim [STIM_SIZE];
    int           n_mem;
    int           n_sq;
    int           n_exp;
    int           n_taken;
    int           ar_count;
    int           tgt_pos;
    xaddr_t       last_ar;
    xaddr_t       rd_q [$];
    int           r_wait;
    int           reset_cycles;
    logic [31:0]  rng;
    int           cycles;
    int           limit;
    int           entry_errs;
    int           addr_errs;
    int           flag_errs;
    int           other_errs;

    fetch_top fetch_top_inst (
        .clk           (clk),
        .i_rst_n       (rst_n),
        .o_arvalid     (arvalid),
        .o_araddr      (araddr),
        .i_arready     (arready),
        .i_rvalid      (rvalid),
        .i_rdata       (rdata),
        .i_rresp       (rresp),
        .o_rready      (rready),
        .i_stall       (stall),
        .i_squash      (squash),
        .i_squash_pc   (squash_pc),
        .o_fetch_vld   (fetch_vld),
        .o_fetch_entry (fetch_entry)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // a section ends at the first slot left all ones
    function automatic int count_section(input int base, input int slots);
        int n;
        n = 0;
        while (n < slots && stim[base + n] != '1) begin
            n++;
        end
        return n;
    endfunction

    // returns {err, data} with unmapped words read as a non-branch fill
    function automatic logic [32:0] mem_read(input xaddr_t addr);
        logic [32:0] word;
        word = {1'b0, addr[31:7] ^ addr[24:0], 7'b0010011};
        for (int i = 0; i < n_mem; i++) begin
            if (stim[MEM_BASE + i][63:32] == addr) begin
                word = {stim[MEM_BASE + i][64], stim[MEM_BASE + i][31:0]};
            end
        end
        return word;
    endfunction

    // returns {found, squash pc} for a jalr or faulting pc
    function automatic logic [32:0] squash_lookup(input xaddr_t pc);
        logic [32:0] res;
        res = '0;
        for (int i = 0; i < n_sq; i++) begin
            if (stim[SQ_BASE + i][63:32] == pc) begin
                res = {1'b1, stim[SQ_BASE + i][31:0]};
            end
        end
        return res;
    endfunction

    // index of the next expected entry that does not follow its predecessor by 4
    function automatic int next_target(input int start);
        int i;
        i = start;
        while (i < n_exp
                && stim[EXP_BASE + i][67:36] == stim[EXP_BASE + i - 1][67:36] + 32'd4) begin
            i++;
        end
        return i;
    endfunction

    task automatic check_entry(input fetch_entry_t got, input fetch_entry_t exp);
        if (got !== exp) begin
            $display("[ERROR] o_fetch_entry: got %h, expected %h", got, exp);
            entry_errs++;
        end
    endtask

    task automatic check_araddr(input xaddr_t got, input xaddr_t exp);
        if (got !== exp) begin
            $display("[ERROR] o_araddr: got %h, expected %h", got, exp);
            addr_errs++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got %h, expected %h", name, got, exp);
            flag_errs++;
        end
    endtask

    task automatic report_counts();
        $display("received %0d of %0d entries; errors: entry %0d, araddr %0d, flag %0d, other %0d",
                 n_taken, n_exp, entry_errs, addr_errs, flag_errs, other_errs);
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= limit) begin
            $display("timeout after %0d cycles, not all expected entries arrived", cycles);
            other_errs++;
            report_counts();
            $display("Done: errors found");
            $finish;
        end
    end

    // all inputs change here while outputs hold since the last rising edge
    always @(negedge clk) begin
        logic [32:0]  word;
        logic [32:0]  sq;
        fetch_entry_t exp_e;
        xaddr_t       exp_addr;
        if (reset_cycles < 2) begin
            reset_cycles++;
            if (reset_cycles == 2) begin
                check_flag("o_fetch_vld", fetch_vld, 1'b0);
                check_flag("o_arvalid", arvalid, 1'b0);
                rst_n = 1'b1;
            end
        end else begin
            // read data is never refused
            if (rvalid) begin
                check_flag("o_rready", rready, 1'b1);
            end
            // R beat transferred at the last rising edge
            if (rvalid && rready) begin
                void'(rd_q.pop_front());
                rvalid = 1'b0;
                rng = xorshift(rng);
                r_wait = int'(rng[5:4]);
            end
            if (!rvalid && rd_q.size() > 0) begin
                if (r_wait > 0) begin
                    r_wait--;
                end else begin
                    word = mem_read(rd_q[0]);
                    rvalid = 1'b1;
                    rdata = word[31:0];
                    rresp = word[32] ? 2'b10 : 2'b00;
                end
            end

            // AR transfer happens at the next rising edge
            rng = xorshift(rng);
            arready = (rng[1:0] != 2'b00);
            if (arvalid && arready) begin
                // off the +4 sequence, fetch must land on the next jump target
                exp_addr = last_ar + 32'd4;
                if (ar_count == 0) begin
                    exp_addr = `RESET_PC;
                end else if (araddr != exp_addr) begin
                    tgt_pos = next_target(tgt_pos + 1);
                    if (tgt_pos < n_exp) begin
                        exp_addr = stim[EXP_BASE + tgt_pos][67:36];
                    end
                end
                check_araddr(araddr, exp_addr);
                rd_q.push_back(araddr);
                last_ar = araddr;
                ar_count++;
            end

            // the backend squashes as it takes a jalr or faulting entry
            rng = xorshift(rng);
            stall = (rng[1:0] == 2'b00);
            squash = 1'b0;
            if (fetch_vld && !stall && n_taken < n_exp) begin
                exp_e = stim[EXP_BASE + n_taken];
                check_entry(fetch_entry, exp_e);
                n_taken++;
                if (exp_e.br_kind == BR_JALR || exp_e.except == EXC_ACCESS) begin
                    sq = squash_lookup(exp_e.pc);
                    if (sq[32]) begin
                        squash = 1'b1;
                        squash_pc = sq[31:0];
                    end else begin
                        $display("no squash pc given for pc %h", exp_e.pc);
                        other_errs++;
                    end
                end
            end
        end
    end

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        arready = 1'b0;
        rvalid = 1'b0;
        rdata = '0;
        rresp = 2'b00;
        stall = 1'b0;
        squash = 1'b0;
        squash_pc = '0;
        rng = 32'd12856;
        r_wait = 0;
        reset_cycles = 0;
        cycles = 0;
        n_taken = 0;
        ar_count = 0;
        tgt_pos = 0;
        last_ar = '0;
        entry_errs = 0;
        addr_errs = 0;
        flag_errs = 0;
        other_errs = 0;
        for (int i = 0; i < STIM_SIZE; i++) begin
            stim[i] = '1;
        end
        $readmemh("tb/fetch_stimulus.txt", stim);
        n_mem = count_section(MEM_BASE, SQ_BASE - MEM_BASE);
        n_sq = count_section(SQ_BASE, EXP_BASE - SQ_BASE);
        n_exp = count_section(EXP_BASE, STIM_SIZE - EXP_BASE);
        limit = 40 * n_exp + 200;
        if (n_exp == 0) begin
            $display("stimulus file holds no expected entries");
            other_errs++;
        end
        wait (rst_n && n_taken == n_exp);
        report_counts();
        if (entry_errs + addr_errs + flag_errs + other_errs == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== verilog/fetch_top.sv ====
`timescale 1ns/1ps

module fetch_top import fetch_pkg::*; (
    input  logic         clk,
    input  logic         i_rst_n,

    // AXI4-Lite read port
    output logic         o_arvalid,
    output xaddr_t       o_araddr,
    input  logic         i_arready,
    input  logic         i_rvalid,
    input  inst_t        i_rdata,
    input  logic [1:0]   i_rresp,
    output logic         o_rready,

    // backend port
    input  logic         i_stall,
    input  logic         i_squash,
    input  xaddr_t       i_squash_pc,
    output logic         o_fetch_vld,
    output fetch_entry_t o_fetch_entry
);

    fetch_tag_t  tag;
    logic        tag_push;
    logic        req_rdy;
    epoch_t      epoch;
    redirect_t   redirect;
    logic        word_vld;
    fetch_word_t word;
    logic        pop;

    fetch_req_gen fetch_req_gen_inst (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_arready   (i_arready),
        .o_arvalid   (o_arvalid),
        .o_araddr    (o_araddr),
        .i_req_rdy   (req_rdy),
        .o_tag       (tag),
        .o_tag_push  (tag_push),
        .i_redirect  (redirect),
        .i_squash    (i_squash),
        .i_squash_pc (i_squash_pc),
        .o_epoch     (epoch)
    );

    fetch_resp_buffer fetch_resp_buffer_inst (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_tag      (tag),
        .i_tag_push (tag_push),
        .o_req_rdy  (req_rdy),
        .i_rvalid   (i_rvalid),
        .i_rdata    (i_rdata),
        .i_rresp    (i_rresp),
        .o_rready   (o_rready),
        .i_pop      (pop),
        .o_word_vld (word_vld),
        .o_word     (word)
    );

    pre_decoder pre_decoder_inst (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_word_vld    (word_vld),
        .i_word        (word),
        .o_pop         (pop),
        .i_epoch       (epoch),
        .o_redirect    (redirect),
        .i_stall       (i_stall),
        .i_squash      (i_squash),
        .o_fetch_vld   (o_fetch_vld),
        .o_fetch_entry (o_fetch_entry)
    );

endmodule

// ==== verilog/pre_decoder.sv ====
`timescale 1ns/1ps

module pre_decoder import fetch_pkg::*; (
    input  logic         clk,
    input  logic         i_rst_n,

    // from the response buffer
    input  logic         i_word_vld,
    input  fetch_word_t  i_word,
    output logic         o_pop,

    // epoch check and redirect toward the producer
    input  epoch_t       i_epoch,
    output redirect_t    o_redirect,

    // backend port
    input  logic         i_stall,
    input  logic         i_squash,
    output logic         o_fetch_vld,
    output fetch_entry_t o_fetch_entry
);

    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;

    dec_state_e state;
    logic       redirect_vld;
    xaddr_t     redirect_pc;
    logic       stale;
    logic       drop;
    logic       out_free;
    logic       load;
    logic [6:0] opcode;
    xaddr_t     j_imm;
    xaddr_t     jal_target;
    xaddr_t     seq_pc;
    br_kind_e   kind;
    logic       jal_redirect;

    // while a redirect is out or a squash arrives, the epoch is about to flip
    assign stale = (i_word.epoch != i_epoch) || redirect_vld || i_squash;
    assign drop = stale || (state == DEC_HALT);
    assign out_free = !o_fetch_vld || !i_stall;

    assign o_pop = i_word_vld && (drop || out_free);
    assign load = i_word_vld && !drop && out_free;

    assign opcode = i_word.inst[6:0];

    always_comb begin
        kind = BR_NONE;
        // a faulted word has no meaningful opcode
        if (!i_word.err) begin
            case (opcode)
                OP_JAL:    kind = BR_JAL;
                OP_JALR:   kind = BR_JALR;
                OP_BRANCH: kind = BR_COND;
                default:   kind = BR_NONE;
            endcase
        end
    end

    // J-type immediate
    assign j_imm = {{12{i_word.inst[31]}}, i_word.inst[19:12], i_word.inst[20],
                    i_word.inst[30:21], 1'b0};
    assign jal_target = i_word.pc + j_imm;
    assign seq_pc = i_word.pc + 32'd4;

    // fetch always predicts sequential, so any other jal target is a miss
    assign jal_redirect = (kind == BR_JAL) && (jal_target != seq_pc);

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            state        <= DEC_RUN;
            o_fetch_vld  <= 1'b0;
            redirect_vld <= 1'b0;
        end else begin
            redirect_vld <= load && jal_redirect;
            if (i_squash) begin
                state       <= DEC_RUN;
                o_fetch_vld <= 1'b0;
            end else if (load) begin
                o_fetch_vld <= 1'b1;
                // hold delivery after a fault until the backend squashes
                if (i_word.err) begin
                    state <= DEC_HALT;
                end
            end else if (!i_stall) begin
                o_fetch_vld <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            o_fetch_entry <= '{
                pc:      i_word.pc,
                inst:    i_word.inst,
                br_kind: kind,
                except:  i_word.err ? EXC_ACCESS : EXC_NONE
            };
            redirect_pc <= jal_target;
        end
    end

    assign o_redirect = '{vld: redirect_vld, pc: redirect_pc};

endmodule

// ==== verilog/fetch_resp_buffer.sv ====
`timescale 1ns/1ps
`include "fetch_params.svh"

module fetch_resp_buffer import fetch_pkg::*; (
    input  logic        clk,
    input  logic        i_rst_n,

    // from the producer at AR acceptance
    input  fetch_tag_t  i_tag,
    input  logic        i_tag_push,
    output logic        o_req_rdy,

    // AXI4-Lite R channel
    input  logic        i_rvalid,
    input  inst_t       i_rdata,
    input  logic [1:0]  i_rresp,
    output logic        o_rready,

    // to the pre-decoder
    input  logic        i_pop,
    output logic        o_word_vld,
    output fetch_word_t o_word
);

    localparam int DEPTH = `FETCH_BUF_DEPTH;
    localparam int AW = $clog2(DEPTH);

    fetch_tag_t    tag_mem [DEPTH];
    logic [AW-1:0] tag_wr_ptr;
    logic [AW-1:0] tag_rd_ptr;
    fetch_tag_t    head_tag;

    fetch_word_t   word_mem [DEPTH];
    logic [AW:0]   word_wr_ptr;
    logic [AW:0]   word_rd_ptr;

    // buffered words plus reads in flight
    logic [AW:0]   used_cnt;
    logic          r_fire;

    // every read already owns a slot, so R is never refused
    assign o_rready = 1'b1;
    assign r_fire = i_rvalid && o_rready;

    // tag fifo, one entry per accepted read
    always_ff @(posedge clk) begin
        if (i_tag_push) begin
            tag_mem[tag_wr_ptr] <= i_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            tag_wr_ptr <= '0;
            tag_rd_ptr <= '0;
        end else begin
            if (i_tag_push) begin
                tag_wr_ptr <= tag_wr_ptr + 1'b1;
            end
            if (r_fire) begin
                tag_rd_ptr <= tag_rd_ptr + 1'b1;
            end
        end
    end

    // responses are in order, the oldest tag belongs to this beat
    assign head_tag = tag_mem[tag_rd_ptr];

    // word fifo
    always_ff @(posedge clk) begin
        if (r_fire) begin
            word_mem[word_wr_ptr[AW-1:0]] <= '{
                pc:    head_tag.pc,
                epoch: head_tag.epoch,
                inst:  i_rdata,
                err:   (i_rresp != 2'b00)
            };
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            word_wr_ptr <= '0;
            word_rd_ptr <= '0;
        end else begin
            if (r_fire) begin
                word_wr_ptr <= word_wr_ptr + 1'b1;
            end
            if (i_pop) begin
                word_rd_ptr <= word_rd_ptr + 1'b1;
            end
        end
    end

    assign o_word_vld = (word_wr_ptr != word_rd_ptr);
    assign o_word = word_mem[word_rd_ptr[AW-1:0]];

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            used_cnt <= '0;
        end else begin
            case ({i_tag_push, i_pop})
                2'b10:   used_cnt <= used_cnt + 1'b1;
                2'b01:   used_cnt <= used_cnt - 1'b1;
                default: used_cnt <= used_cnt;
            endcase
        end
    end

    assign o_req_rdy = (used_cnt < DEPTH);

endmodule

// ==== verilog/fetch_req_gen.sv ====
`timescale 1ns/1ps
`include "fetch_params.svh"

module fetch_req_gen import fetch_pkg::*; (
    input  logic       clk,
    input  logic       i_rst_n,

    // AXI4-Lite AR channel
    input  logic       i_arready,
    output logic       o_arvalid,
    output xaddr_t     o_araddr,

    // space check and tag push toward the response buffer
    input  logic       i_req_rdy,
    output fetch_tag_t o_tag,
    output logic       o_tag_push,

    // redirect from pre-decode, squash from the backend
    input  redirect_t  i_redirect,
    input  logic       i_squash,
    input  xaddr_t     i_squash_pc,
    output epoch_t     o_epoch
);

    req_state_e state;
    xaddr_t     pc;
    epoch_t     epoch;
    logic       ar_fire;
    logic       reload;
    xaddr_t     reload_pc;

    assign ar_fire = o_arvalid && i_arready;

    // squash wins over a redirect in the same cycle
    assign reload = i_squash || i_redirect.vld;
    assign reload_pc = i_squash ? i_squash_pc : i_redirect.pc;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            state <= REQ_ISSUE;
            pc    <= `RESET_PC;
            epoch <= 1'b0;
        end else if (reload) begin
            // pending AR is dropped, the new pc goes out from the next cycle
            state <= REQ_ISSUE;
            pc    <= {reload_pc[`XLEN-1:2], 2'b00};
            epoch <= ~epoch;
        end else begin
            case (state)
                REQ_ISSUE: begin
                    // only raise valid when the buffer has reserved a slot
                    if (i_req_rdy) begin
                        state <= REQ_WAIT;
                    end
                end
                REQ_WAIT: begin
                    if (ar_fire) begin
                        state <= REQ_ISSUE;
                        pc    <= pc + `XLEN'd4;
                    end
                end
                default: begin
                    state <= REQ_ISSUE;
                end
            endcase
        end
    end

    // valid and address both come from registers, so they hold until accepted
    assign o_arvalid = (state == REQ_WAIT);
    assign o_araddr  = pc;

    // tag travels with the handshake pulse; a read accepted during a
    // reload still carries the old epoch and is dropped later as stale
    assign o_tag_push = ar_fire;
    assign o_tag = '{pc: pc, epoch: epoch};

    assign o_epoch = epoch;

endmodule

// ==== verilog/fetch_pkg.sv ====
`include "fetch_params.svh"

package fetch_pkg;

    typedef logic [`XLEN-1:0] xaddr_t;
    typedef logic [31:0] inst_t;
    // flips on every redirect or squash
    typedef logic epoch_t;

    typedef enum logic [1:0] {
        BR_NONE = 2'd0,
        BR_COND = 2'd1,
        BR_JAL  = 2'd2,
        BR_JALR = 2'd3
    } br_kind_e;

    typedef enum logic [1:0] {
        EXC_NONE   = 2'd0,
        EXC_ACCESS = 2'd1
    } except_e;

    // REQ_WAIT holds arvalid and the address until the handshake
    typedef enum logic {
        REQ_ISSUE = 1'b0,
        REQ_WAIT  = 1'b1
    } req_state_e;

    typedef enum logic {
        DEC_RUN  = 1'b0,
        DEC_HALT = 1'b1
    } dec_state_e;

    typedef struct packed {
        xaddr_t pc;
        epoch_t epoch;
    } fetch_tag_t;

    typedef struct packed {
        xaddr_t pc;
        epoch_t epoch;
        inst_t  inst;
        logic   err;
    } fetch_word_t;

    typedef struct packed {
        xaddr_t   pc;
        inst_t    inst;
        br_kind_e br_kind;
        except_e  except;
    } fetch_entry_t;

    typedef struct packed {
        logic   vld;
        xaddr_t pc;
    } redirect_t;

endpackage

// ==== verilog/fetch_params.svh ====
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// words in one aligned fetch block
`define FETCH_BLOCK_WORDS 4
// response buffer entries, buffered words plus reads in flight
`define FETCH_BUF_DEPTH 4
`define RESET_PC 32'h0000_0100
`define XLEN 32

`endif
